// ==== dcache_pkg.sv ====
// Data cache shared definitions
// Address split, payload types and cache geometry
`default_nettype none

package dcache_pkg;

    // Address split is tag, index, byte offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    localparam int SETS  = 256;
    localparam int WORDS = 4;

    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // Word 0 sits in the low bits
    typedef word_t [WORDS-1:0]   line_t;

    typedef logic [31:0]         addr_t;
    typedef logic [1:0]          beat_t;

endpackage

`default_nettype wire

// ==== dcache_array.sv ====
// Cache storage array
// One synchronous write port, combinational read, any payload type
`default_nettype none
`timescale 1ns/1ps

module dcache_array
    import dcache_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = SETS
) (
    input  logic   clk,
    input  logic   we,
    input  index_t waddr,
    input  entry_t wentry,
    input  index_t raddr,
    output entry_t rentry
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wentry;
        end
    end

    // Read data follows the address within the cycle
    assign rentry = mem[raddr];

endmodule

`default_nettype wire

// ==== dcache_refill_counter.sv ====
// Refill beat counter
// Places returned memory beats into their word slots and
// presents the whole line on the last beat
`default_nettype none
`timescale 1ns/1ps

module dcache_refill_counter
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  start,
    input  logic  ret_valid,
    input  logic  ret_last,
    input  word_t ret_data,
    output logic  done,
    output line_t line
);

    beat_t beat;
    line_t line_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (start) begin
            beat <= '0;
        end else if (ret_valid) begin
            beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line_q[beat] <= ret_data;
        end
    end

    // Last beat bypasses the register so the line is whole at done
    always_comb begin
        line = line_q;
        if (ret_valid) begin
            line[beat] = ret_data;
        end
    end

    assign done = ret_valid && ret_last;

    a_last_on_beat3: assert property (@(posedge clk) disable iff (!resetn)
        (ret_valid && ret_last) |-> (beat == beat_t'(WORDS - 1)));

endmodule

`default_nettype wire

// ==== dcache_write_buffer.sv ====
// Store write buffer
// Holds one hit store and writes its line back to the data array
// the next cycle with the strobed bytes merged in
`default_nettype none
`timescale 1ns/1ps

module dcache_write_buffer
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       load,
    input  logic       way,
    input  index_t     index_in,
    input  offset_t    offset,
    input  strb_t      strb,
    input  word_t      data,
    input  line_t      line,
    output logic       busy,
    output index_t     index,
    output logic [1:0] we,
    output line_t      wline
);

    logic    busy_q;
    logic    way_q;
    index_t  index_q;
    offset_t offset_q;
    strb_t   strb_q;
    word_t   data_q;
    line_t   line_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            way_q    <= way;
            index_q  <= index_in;
            offset_q <= offset;
            strb_q   <= strb;
            data_q   <= data;
            line_q   <= line;
        end
    end

    // Byte merge into the addressed word
    always_comb begin
        wline = line_q;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb_q[b]) begin
                wline[offset_q[OFFSET_W-1:2]][8*b +: 8] = data_q[8*b +: 8];
            end
        end
    end

    assign busy  = busy_q;
    assign index = index_q;
    assign we    = busy_q ? {way_q, !way_q} : 2'b00;

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
// Data cache controller
// Lookup and miss FSM, hit detection, valid and dirty state,
// victim choice and the CPU and memory side strobes
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int DEPTH = SETS
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       valid,
    input  logic       op,
    input  index_t     index,
    input  tag_t       tag,
    input  offset_t    offset,
    input  strb_t      wstrb,
    input  word_t      wdata,
    input  tag_t       way0_tag,
    input  tag_t       way1_tag,
    input  line_t      way0_line,
    input  line_t      way1_line,
    input  logic       wr_rdy,
    input  logic       rd_rdy,
    input  logic       refill_done,
    input  line_t      refill_line,
    input  logic       wb_busy,
    input  index_t     wb_index,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    output logic [1:0] tag_we,
    output logic [1:0] data_we,
    output index_t     array_index,
    output tag_t       fill_tag,
    output line_t      fill_line,
    output logic       wr_req,
    output addr_t      wr_addr,
    output line_t      wr_data,
    output logic       rd_req,
    output addr_t      rd_addr,
    output logic       refill_start,
    output logic       wb_load,
    output logic       wb_way,
    output index_t     wb_index_in,
    output offset_t    wb_offset,
    output strb_t      wb_strb,
    output word_t      wb_data,
    output line_t      wb_line
);

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REPLACE, REFILL} state_t;

    state_t state;
    state_t state_next;

    // Request buffer
    logic    op_rb;
    index_t  index_rb;
    tag_t    tag_rb;
    offset_t offset_rb;
    strb_t   wstrb_rb;
    word_t   wdata_rb;

    logic [1:0][DEPTH-1:0] valid_q;
    logic [1:0][DEPTH-1:0] dirty_q;

    logic       toggle;
    logic       victim_way;
    logic       way0_hit;
    logic       way1_hit;
    logic       hit;
    logic       store_hit;
    logic       take;
    logic       need_wb;
    logic       install;
    logic [1:0] refill_we;
    line_t      hit_line;
    tag_t       victim_tag;
    line_t      victim_line;

    assign way0_hit  = valid_q[0][index_rb] && (way0_tag == tag_rb);
    assign way1_hit  = valid_q[1][index_rb] && (way1_tag == tag_rb);
    assign hit       = way0_hit || way1_hit;
    assign hit_line  = way1_hit ? way1_line : way0_line;
    assign rdata     = hit_line[offset_rb[OFFSET_W-1:2]];
    assign store_hit = (state == LOOKUP) && hit && op_rb;

    // Same index waits until the pending store has been merged
    assign addr_ok = ((state == IDLE) || ((state == LOOKUP) && hit))
                     && !(store_hit && (index == index_rb))
                     && !(wb_busy && (index == wb_index));
    assign take    = valid && addr_ok;
    assign data_ok = (state == LOOKUP) && hit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:
                if (take)
                    state_next = LOOKUP;
            LOOKUP:
                if (!hit)
                    state_next = MISS;
                else if (!take)
                    state_next = IDLE;
            MISS:
                if (!wb_busy && (!need_wb || wr_rdy))
                    state_next = REPLACE;
            REPLACE:
                if (rd_rdy)
                    state_next = REFILL;
            REFILL:
                if (refill_done)
                    state_next = LOOKUP;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_rb     <= op;
            index_rb  <= index;
            tag_rb    <= tag;
            offset_rb <= offset;
            wstrb_rb  <= wstrb;
            wdata_rb  <= wdata;
        end
    end

    // Free-running toggle picks the victim at the miss
    always_ff @(posedge clk) begin
        if (!resetn) begin
            toggle     <= 1'b0;
            victim_way <= 1'b0;
        end else begin
            toggle <= !toggle;
            if ((state == LOOKUP) && !hit) begin
                victim_way <= toggle;
            end
        end
    end

    assign install   = (state == REFILL) && refill_done;
    assign refill_we = install ? {victim_way, !victim_way} : 2'b00;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (install) begin
            valid_q[victim_way][index_rb] <= 1'b1;
            dirty_q[victim_way][index_rb] <= 1'b0;
        end else if (store_hit) begin
            dirty_q[way1_hit][index_rb] <= 1'b1;
        end
    end

    assign victim_tag  = victim_way ? way1_tag : way0_tag;
    assign victim_line = victim_way ? way1_line : way0_line;
    assign need_wb     = valid_q[victim_way][index_rb] && dirty_q[victim_way][index_rb];

    assign wr_req       = (state == MISS) && need_wb && !wb_busy;
    assign wr_addr      = {victim_tag, index_rb, {OFFSET_W{1'b0}}};
    assign wr_data      = victim_line;
    assign rd_req       = (state == REPLACE);
    assign rd_addr      = {tag_rb, index_rb, {OFFSET_W{1'b0}}};
    assign refill_start = rd_req && rd_rdy;

    assign array_index = index_rb;
    assign tag_we      = refill_we;
    assign data_we     = refill_we;
    assign fill_tag    = tag_rb;
    assign fill_line   = refill_line;

    assign wb_load     = store_hit;
    assign wb_way      = way1_hit;
    assign wb_index_in = index_rb;
    assign wb_offset   = offset_rb;
    assign wb_strb     = wstrb_rb;
    assign wb_data     = wdata_rb;
    assign wb_line     = hit_line;

    // Write-back request holds its line until the memory takes it
    a_wr_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        (wr_req && !wr_rdy) |=> (wr_req && $stable(wr_addr) && $stable(wr_data)));

    // A lookup is entered only from an accepted request or a finished refill
    a_data_ok_follows: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> ($past(take) || $past(install)));

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// Two-way set-associative write-back data cache
// Controller, refill counter, write buffer and per-way tag and data arrays
`default_nettype none
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int DEPTH = SETS
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  logic    op,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy,
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  logic    ret_last,
    input  word_t   ret_data
);

    tag_t       way_tag [2];
    line_t      way_line [2];
    logic [1:0] tag_we;
    logic [1:0] data_we;
    logic [1:0] wb_we;
    index_t     array_index;
    index_t     data_waddr;
    tag_t       fill_tag;
    line_t      fill_line;
    line_t      refill_line;
    logic       refill_done;
    logic       refill_start;
    logic       wb_load;
    logic       wb_way;
    logic       wb_busy;
    index_t     wb_index;
    index_t     wb_index_in;
    offset_t    wb_offset;
    strb_t      wb_strb;
    word_t      wb_data;
    line_t      wb_line;
    line_t      wb_wline;

    dcache_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .way0_tag     (way_tag[0]),
        .way1_tag     (way_tag[1]),
        .way0_line    (way_line[0]),
        .way1_line    (way_line[1]),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .wb_busy      (wb_busy),
        .wb_index     (wb_index),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .array_index  (array_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .refill_start (refill_start),
        .wb_load      (wb_load),
        .wb_way       (wb_way),
        .wb_index_in  (wb_index_in),
        .wb_offset    (wb_offset),
        .wb_strb      (wb_strb),
        .wb_data      (wb_data),
        .wb_line      (wb_line)
    );

    dcache_refill_counter u_refill (
        .clk       (clk),
        .resetn    (resetn),
        .start     (refill_start),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .done      (refill_done),
        .line      (refill_line)
    );

    dcache_write_buffer u_wbuf (
        .clk      (clk),
        .resetn   (resetn),
        .load     (wb_load),
        .way      (wb_way),
        .index_in (wb_index_in),
        .offset   (wb_offset),
        .strb     (wb_strb),
        .data     (wb_data),
        .line     (wb_line),
        .busy     (wb_busy),
        .index    (wb_index),
        .we       (wb_we),
        .wline    (wb_wline)
    );

    // Store merge owns the data write port while busy
    assign data_waddr = wb_busy ? wb_index : array_index;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic  data_wr;
        line_t data_wentry;

        assign data_wr     = data_we[w] | wb_we[w];
        assign data_wentry = wb_we[w] ? wb_wline : fill_line;

        dcache_array #(
            .entry_t (tag_t),
            .DEPTH   (DEPTH)
        ) u_tag (
            .clk    (clk),
            .we     (tag_we[w]),
            .waddr  (array_index),
            .wentry (fill_tag),
            .raddr  (array_index),
            .rentry (way_tag[w])
        );

        dcache_array #(
            .entry_t (line_t),
            .DEPTH   (DEPTH)
        ) u_data (
            .clk    (clk),
            .we     (data_wr),
            .waddr  (data_waddr),
            .wentry (data_wentry),
            .raddr  (array_index),
            .rentry (way_line[w])
        );
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
// Free-running clock, reset held low for a fixed number of cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// Backing memory for the cache testbench
// Answers write-backs and refills with random ready and beat gaps
`default_nettype none
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output logic  ret_last,
    output word_t ret_data
);

    // Window of tags 0..3 by indices 0..7, four words each
    word_t mem [128];
    logic  busy;
    beat_t beat;
    addr_t raddr_q;

    initial begin : fill_mem
        addr_t a;
        for (int k = 0; k < 128; k++) begin
            a = '0;
            a[13:12] = k[6:5];
            a[6:4] = k[4:2];
            a[3:2] = k[1:0];
            mem[k] = (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
        wr_rdy = 1'b0;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        busy = 1'b0;
        beat = '0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            wr_rdy    <= 1'b0;
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            busy      <= 1'b0;
            beat      <= '0;
        end else begin
            wr_rdy    <= ($urandom % 4) != 0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req && wr_rdy) begin
                for (int w = 0; w < WORDS; w++) begin
                    mem[{wr_addr[13:12], wr_addr[6:4], w[1:0]}] <= wr_data[w];
                end
            end
            if (busy) begin
                // Beats go out in order, with random idle cycles between them
                rd_rdy <= 1'b0;
                if (($urandom % 3) != 0) begin
                    ret_valid <= 1'b1;
                    ret_data  <= mem[{raddr_q[13:12], raddr_q[6:4], beat}];
                    ret_last  <= (beat == 2'd3);
                    beat      <= beat + 2'd1;
                    if (beat == 2'd3) begin
                        busy <= 1'b0;
                    end
                end
            end else if (rd_req && rd_rdy) begin
                busy    <= 1'b1;
                raddr_q <= rd_addr;
                beat    <= '0;
                rd_rdy  <= 1'b0;
            end else begin
                rd_rdy <= ($urandom % 2) == 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
// Testbench for the two-way write-back data cache
// Random loads and stores checked against a golden word memory
`default_nettype none
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_REQ      = 2000;
    localparam int N_TAGS     = 3;

    logic    clk;
    logic    resetn;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;

    word_t       golden [128];
    logic        exp_op [$];
    word_t       exp_data [$];
    addr_t       exp_addr [$];
    int          error_count;
    int unsigned seed;
    int          tsel;
    word_t       r;
    logic        ready;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (8)
    ) u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    dcache_top #(
        .DEPTH (SETS)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    // Golden slot is tag bits 1:0, index bits 2:0, word number
    function automatic logic [6:0] golden_slot(addr_t a);
        return {a[13:12], a[6:4], a[3:2]};
    endfunction

    function automatic line_t golden_line(addr_t a);
        line_t l;
        addr_t wa;
        for (int w = 0; w < WORDS; w++) begin
            wa = a;
            wa[3:2] = w[1:0];
            l[w] = golden[golden_slot(wa)];
        end
        return l;
    endfunction

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic verify_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic expect_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic require_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Worst case of 40 cycles per request
    initial begin
        #(N_REQ * 40 * CLK_PERIOD);
        stop_on_error("Watchdog expired before all requests completed");
    end

    // Monitor samples mid-cycle, where all DUT outputs have settled
    always @(negedge clk) begin : monitor
        addr_t a;
        word_t w;
        if (resetn) begin
            if (rd_req && wr_req) begin
                stop_on_error("rd_req and wr_req were high in the same cycle");
            end
            if (data_ok) begin
                if (exp_op.size() == 0) begin
                    stop_on_error("data_ok arrived with no request pending");
                end
                if (!exp_op[0]) begin
                    compare_word("load rdata", exp_data[0], rdata);
                end
                void'(exp_op.pop_front());
                void'(exp_data.pop_front());
                void'(exp_addr.pop_front());
            end
            if (rd_req) begin
                expect_addr("refill address", {exp_addr[0][31:4], 4'b0000}, rd_addr);
            end
            if (wr_req && wr_rdy) begin
                // Victim sits in the set of the missing request, tags stay in the window
                expect_addr("write-back address",
                            {18'd0, wr_addr[13:12], exp_addr[0][11:4], 4'b0000},
                            wr_addr);
                verify_line("write-back data", golden_line(wr_addr), wr_data);
            end
            if (valid && addr_ok) begin
                a = {tag, index, offset};
                w = golden[golden_slot(a)];
                exp_op.push_back(op);
                exp_data.push_back(w);
                exp_addr.push_back(a);
                if (op) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            w[8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                    golden[golden_slot(a)] = w;
                end
            end
        end
    end

    initial begin
        error_count = 0;
        seed = 68209;
        void'($urandom(seed));
        valid = 1'b0;
        op = 1'b0;
        index = '0;
        tag = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        wait (resetn === 1'b1);
        // Golden memory starts from the backing memory's initial contents
        for (int k = 0; k < 128; k++) begin
            golden[k] = u_mem.mem[k];
        end
        @(negedge clk);
        require_flag("addr_ok after reset", 1'b1, addr_ok);
        require_flag("data_ok after reset", 1'b0, data_ok);
        require_flag("rd_req after reset", 1'b0, rd_req);
        require_flag("wr_req after reset", 1'b0, wr_req);
        @(posedge clk);
        for (int n = 0; n < N_REQ; n++) begin
            if (($urandom % 5) == 0) begin
                valid <= 1'b0;
                @(posedge clk);
            end
            r = $urandom;
            tsel = $urandom % N_TAGS;
            valid  <= 1'b1;
            op     <= r[0];
            offset <= {r[2:1], 2'b00};
            wstrb  <= r[0] ? r[6:3] : 4'b0000;
            tag    <= {18'd0, tsel[1:0]};
            index  <= {5'd0, r[11:9]};
            wdata  <= $urandom;
            // Hold the request until the cache takes it
            do begin
                @(negedge clk);
                ready = addr_ok;
                @(posedge clk);
            end while (!ready);
        end
        valid <= 1'b0;
        while (exp_op.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
dcache_pkg.sv
dcache_array.sv
dcache_refill_counter.sv
dcache_write_buffer.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_array.sv
  - dcache_refill_counter.sv
  - dcache_write_buffer.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_mem_model.sv
      - tb_dcache.sv
